// File: verilog/frontend_macros.svh
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

////////////////////
// datapath widths
////////////////////

// address and pc width
`define XLEN 32

// one memory transfer, always a full block
`define BLOCK_BITS 64

// memory transaction tag, zero is reserved for "refused / no reply"
`define MEM_TAG_BITS 4

////////////////////
// icache geometry
////////////////////

// direct mapped, one block per line
`define ICACHE_LINES 32

// instruction word width
`define INST_BITS 32

////////////////////
// fetch constants
////////////////////

// pc after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP 32'h0000_0013

`endif

// File: verilog/frontend_pkg.sv
`include "frontend_macros.svh"

package frontend_pkg;

    ////////////////////
    // memory bus
    ////////////////////

    // command on the shared memory port
    // encoding follows the memory model, none is idle
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // transaction tag
    // nonzero response = accepted, zero = refused
    // mem2proc_tag of zero = no reply this cycle
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    ////////////////////
    // fetch to decode
    ////////////////////

    // contents of the fetch/decode stage register
    typedef struct packed {
        // packet holds a real instruction
        logic                   valid;
        // raw instruction word
        logic [`INST_BITS-1:0]  inst;
        // address it was fetched from
        logic [`XLEN-1:0]       pc;
        // sequential successor, pc + 4
        logic [`XLEN-1:0]       npc;
    } fetch_packet_t;

endpackage

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module mem_arbiter (
    // data side from outside
    input  frontend_pkg::bus_command_t data_command,
    input  logic [`XLEN-1:0]           data_addr,
    input  logic [`BLOCK_BITS-1:0]     data_wdata,
    // instruction side, from the icache
    input  frontend_pkg::bus_command_t imem_command,
    input  logic [`XLEN-1:0]           imem_addr,
    // accept tag from memory in the request cycle
    input  frontend_pkg::mem_tag_t     mem2proc_response,
    output frontend_pkg::mem_tag_t     imem_response,
    // the single memory port
    output frontend_pkg::bus_command_t proc2mem_command,
    output logic [`XLEN-1:0]           proc2mem_addr,
    output logic [`BLOCK_BITS-1:0]     proc2mem_data
);

    // data side owns the port whenever it asks for it
    logic data_active;

    assign data_active = (data_command == frontend_pkg::bus_load) ||
                         (data_command == frontend_pkg::bus_store);

    ////////////////////
    // port select
    ////////////////////

    always_comb begin
        // default to the instruction side
        proc2mem_command = imem_command;
        proc2mem_addr    = imem_addr;
        // icache never writes
        proc2mem_data    = '0;
        imem_response    = mem2proc_response;

        if (data_active) begin
            proc2mem_command = data_command;
            proc2mem_addr    = data_addr;
            proc2mem_data    = data_wdata;
            // accept belongs to the data request
            // icache sees a refusal and retries later
            imem_response    = '0;
        end
    end

endmodule

// File: verilog/icache.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module icache (
    input  logic                       clock,
    input  logic                       reset,
    // lookup address from fetch
    input  logic [`XLEN-1:0]           fetch_addr,
    // memory side
    input  frontend_pkg::mem_tag_t     imem_response,
    input  frontend_pkg::mem_tag_t     mem2proc_tag,
    input  logic [`BLOCK_BITS-1:0]     mem2proc_data,
    output frontend_pkg::bus_command_t imem_command,
    output logic [`XLEN-1:0]           imem_addr,
    // same-cycle result to fetch
    output logic [`INST_BITS-1:0]      icache_inst,
    output logic                       icache_hit
);

    // byte offset inside a block, then index, then tag
    localparam int OFFSET_BITS = $clog2(`BLOCK_BITS / 8);
    localparam int IDX_BITS    = $clog2(`ICACHE_LINES);
    localparam int TAG_BITS    = `XLEN - IDX_BITS - OFFSET_BITS;

    ////////////////////
    // storage
    ////////////////////

    logic [`BLOCK_BITS-1:0]   line_data [`ICACHE_LINES];
    logic [TAG_BITS-1:0]      line_tag  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] line_valid;

    // lookup fields
    logic [IDX_BITS-1:0]    fetch_idx;
    logic [TAG_BITS-1:0]    fetch_tag;
    logic [`BLOCK_BITS-1:0] fetch_block;

    // outstanding miss
    logic                   miss_pending;
    frontend_pkg::mem_tag_t pend_mem_tag;
    logic [IDX_BITS-1:0]    pend_idx;
    logic [TAG_BITS-1:0]    pend_tag;

    logic req_accepted;
    logic fill_en;

    ////////////////////
    // lookup
    ////////////////////

    assign fetch_idx   = fetch_addr[OFFSET_BITS +: IDX_BITS];
    assign fetch_tag   = fetch_addr[`XLEN-1 -: TAG_BITS];
    assign fetch_block = line_data[fetch_idx];

    assign icache_hit = line_valid[fetch_idx] && (line_tag[fetch_idx] == fetch_tag);

    // addr bit 2 picks the word
    // upper half holds the higher address
    assign icache_inst = fetch_addr[2] ? fetch_block[`BLOCK_BITS-1 -: `INST_BITS]
                                       : fetch_block[`INST_BITS-1:0];

    ////////////////////
    // miss request
    ////////////////////

    // one miss at a time
    // request held every cycle until memory gives a tag
    // bus stays idle while reset is held
    assign imem_command = (!reset && !icache_hit && !miss_pending) ? frontend_pkg::bus_load
                                                                   : frontend_pkg::bus_none;

    // block aligned
    assign imem_addr = {fetch_addr[`XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    assign req_accepted = (imem_command == frontend_pkg::bus_load) && (imem_response != '0);

    // accepted tags are nonzero so an idle bus never matches
    assign fill_en = miss_pending && (mem2proc_tag == pend_mem_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            miss_pending <= 1'b0;
        end else if (fill_en) begin
            miss_pending <= 1'b0;
        end else if (req_accepted) begin
            miss_pending <= 1'b1;
        end
    end

    // reply destination captured at accept time
    // a later redirect does not disturb the fill
    always_ff @(posedge clock) begin
        if (req_accepted) begin
            pend_mem_tag <= imem_response;
            pend_idx     <= fetch_idx;
            pend_tag     <= fetch_tag;
        end
    end

    ////////////////////
    // fill
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[pend_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_en) begin
            line_data[pend_idx] <= mem2proc_data;
            line_tag[pend_idx]  <= pend_tag;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // valid bits only move on a fill and a fill needs a miss in flight
    assert property (@(posedge clock) disable iff (reset)
        (line_valid != $past(line_valid)) |-> $past(miss_pending))
        else $error("[ERROR] icache line became valid with no miss outstanding");

    // once memory took the request the bus stays quiet until the reply
    assert property (@(posedge clock) disable iff (reset)
        req_accepted |=> (imem_command == frontend_pkg::bus_none))
        else $error("[ERROR] icache issued a load at %h with tag %h pending",
                    imem_addr, pend_mem_tag);

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_unit (
    input  logic                        clock,
    input  logic                        reset,
    // back-pressure from decode
    input  logic                        decode_stall,
    // resolved branch from the back end
    input  logic                        branch_req,
    input  logic [`XLEN-1:0]            branch_target,
    // icache result for fetch_addr, same cycle
    input  logic [`INST_BITS-1:0]       icache_inst,
    input  logic                        icache_hit,
    output logic [`XLEN-1:0]            fetch_addr,
    // fetch/decode stage register
    output frontend_pkg::fetch_packet_t fetch_packet
);

    // empty slot in the stage register
    localparam frontend_pkg::fetch_packet_t BUBBLE = '{
        valid: 1'b0,
        inst:  `NOP,
        pc:    '0,
        npc:   '0
    };

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus4;
    // word moves into the stage register this edge
    logic             advance;

    assign pc_plus4   = pc + `XLEN'd4;
    assign advance    = icache_hit && !decode_stall;
    assign fetch_addr = pc;

    ////////////////////
    // program counter
    ////////////////////

    // redirect first, then stall, then sequential
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (branch_req) begin
            pc <= branch_target;
        end else if (advance) begin
            pc <= pc_plus4;
        end
    end

    ////////////////////
    // stage register
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_packet <= BUBBLE;
        end else if (branch_req) begin
            // squash whatever was fetched on the old path
            fetch_packet <= BUBBLE;
        end else if (!decode_stall) begin
            if (icache_hit) begin
                fetch_packet.valid <= 1'b1;
                fetch_packet.inst  <= icache_inst;
                fetch_packet.pc    <= pc;
                fetch_packet.npc   <= pc_plus4;
            end else begin
                // miss in progress
                fetch_packet <= BUBBLE;
            end
        end
        // stalled: hold packet as is
    end

    ////////////////////
    // checks
    ////////////////////

    // targets come from outside, so alignment is only as good as the back end
    assert property (@(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00)
        else $error("[ERROR] fetch pc %h not word aligned", pc);

endmodule

// File: verilog/frontend_top.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module frontend_top (
    input  logic                       clock,
    input  logic                       reset,
    // memory replies
    input  frontend_pkg::mem_tag_t     mem2proc_response,
    input  frontend_pkg::mem_tag_t     mem2proc_tag,
    input  logic [`BLOCK_BITS-1:0]     mem2proc_data,
    // data-side requests
    input  frontend_pkg::bus_command_t data_command,
    input  logic [`XLEN-1:0]           data_addr,
    input  logic [`BLOCK_BITS-1:0]     data_wdata,
    // strobes from the back end
    input  logic                       decode_stall,
    input  logic                       branch_req,
    input  logic [`XLEN-1:0]           branch_target,
    // memory port
    output frontend_pkg::bus_command_t proc2mem_command,
    output logic [`XLEN-1:0]           proc2mem_addr,
    output logic [`BLOCK_BITS-1:0]     proc2mem_data,
    // fetch/decode register, flattened
    output logic                       fetch_valid,
    output logic [`INST_BITS-1:0]      fetch_inst,
    output logic [`XLEN-1:0]           fetch_pc,
    output logic [`XLEN-1:0]           fetch_npc
);

    ////////////////////
    // wires
    ////////////////////

    // icache <-> arbiter
    frontend_pkg::bus_command_t imem_command;
    logic [`XLEN-1:0]           imem_addr;
    frontend_pkg::mem_tag_t     imem_response;

    // fetch <-> icache
    logic [`XLEN-1:0]           fetch_addr;
    logic [`INST_BITS-1:0]      icache_inst;
    logic                       icache_hit;

    frontend_pkg::fetch_packet_t fetch_packet;

    ////////////////////
    // instances
    ////////////////////

    mem_arbiter u_mem_arbiter (
        .data_command      (data_command),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .imem_command      (imem_command),
        .imem_addr         (imem_addr),
        .mem2proc_response (mem2proc_response),
        .imem_response     (imem_response),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data)
    );

    // reply tag and data go to the icache unfiltered
    icache u_icache (
        .clock         (clock),
        .reset         (reset),
        .fetch_addr    (fetch_addr),
        .imem_response (imem_response),
        .mem2proc_tag  (mem2proc_tag),
        .mem2proc_data (mem2proc_data),
        .imem_command  (imem_command),
        .imem_addr     (imem_addr),
        .icache_inst   (icache_inst),
        .icache_hit    (icache_hit)
    );

    fetch_unit u_fetch_unit (
        .clock         (clock),
        .reset         (reset),
        .decode_stall  (decode_stall),
        .branch_req    (branch_req),
        .branch_target (branch_target),
        .icache_inst   (icache_inst),
        .icache_hit    (icache_hit),
        .fetch_addr    (fetch_addr),
        .fetch_packet  (fetch_packet)
    );

    // packet out to loose ports
    assign fetch_valid = fetch_packet.valid;
    assign fetch_inst  = fetch_packet.inst;
    assign fetch_pc    = fetch_packet.pc;
    assign fetch_npc   = fetch_packet.npc;

endmodule

// File: bench/mem_model.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module mem_model (
    input  logic                       clock,
    input  logic                       reset,
    input  frontend_pkg::bus_command_t proc2mem_command,
    input  logic [`XLEN-1:0]           proc2mem_addr,
    // store data is dropped, the image never changes
    input  logic [`BLOCK_BITS-1:0]     proc2mem_data,
    // turn every request away while high
    input  logic                       refuse,
    // cycle number kept with each log entry
    input  int                         stamp,
    output frontend_pkg::mem_tag_t     mem2proc_response,
    output frontend_pkg::mem_tag_t     mem2proc_tag,
    output logic [`BLOCK_BITS-1:0]     mem2proc_data
);

    localparam int LOG_DEPTH = 256;

    frontend_pkg::mem_tag_t next_tag;
    // two stages plus the output register, reply 3 cycles after accept
    frontend_pkg::mem_tag_t pipe_tag  [2];
    logic [`BLOCK_BITS-1:0] pipe_data [2];

    // accepted requests
    logic [`XLEN-1:0]           log_addr  [LOG_DEPTH];
    frontend_pkg::bus_command_t log_cmd   [LOG_DEPTH];
    int                         log_cycle [LOG_DEPTH];
    int                         log_count;

    // word at a is a ^ a5a50000, higher address in the upper half
    function automatic logic [`BLOCK_BITS-1:0] image_block(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] base;
        base = {addr[`XLEN-1:3], 3'b000};
        return {(base + 32'd4) ^ 32'ha5a5_0000, base ^ 32'ha5a5_0000};
    endfunction

    assign mem2proc_response = (!reset && !refuse && proc2mem_command != frontend_pkg::bus_none)
                               ? next_tag : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag      <= frontend_pkg::mem_tag_t'(1);
            pipe_tag[0]   <= '0;
            pipe_tag[1]   <= '0;
            mem2proc_tag  <= '0;
            mem2proc_data <= '0;
            log_count     <= 0;
        end else begin
            pipe_tag[1]   <= pipe_tag[0];
            pipe_data[1]  <= pipe_data[0];
            mem2proc_tag  <= pipe_tag[1];
            mem2proc_data <= pipe_data[1];
            pipe_tag[0]   <= '0;
            if (mem2proc_response != '0) begin
                // tags rotate through 1..15, zero stays reserved
                next_tag <= (next_tag == '1) ? frontend_pkg::mem_tag_t'(1) : next_tag + 1'b1;
                // only loads get a reply
                if (proc2mem_command == frontend_pkg::bus_load) begin
                    pipe_tag[0]  <= mem2proc_response;
                    pipe_data[0] <= image_block(proc2mem_addr);
                end
                if (log_count < LOG_DEPTH) begin
                    log_addr[log_count]  <= proc2mem_addr;
                    log_cmd[log_count]   <= proc2mem_command;
                    log_cycle[log_count] <= stamp;
                    log_count            <= log_count + 1;
                end
            end
        end
    end

endmodule

// File: bench/frontend_tb.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module frontend_tb;

    // packets per test
    // N_RUN each for data, refusal, stall and two redirects
    localparam int N_SEQ = 24;
    localparam int N_RUN = 8;
    // worst miss covers refusals, data traffic, reply latency and fill
    localparam int MISS_WORST = 24;
    localparam int TIMEOUT_CYCLES = (N_SEQ + 5 * N_RUN) * MISS_WORST + 200;
    localparam logic [`XLEN-1:0] DATA_BASE = 32'h1000_0000;

    logic                       clock;
    logic                       reset;
    frontend_pkg::bus_command_t data_command;
    logic [`XLEN-1:0]           data_addr;
    logic [`BLOCK_BITS-1:0]     data_wdata;
    logic                       decode_stall;
    logic                       branch_req;
    logic [`XLEN-1:0]           branch_target;
    logic                       refuse;
    frontend_pkg::mem_tag_t     mem2proc_response;
    frontend_pkg::mem_tag_t     mem2proc_tag;
    logic [`BLOCK_BITS-1:0]     mem2proc_data;
    frontend_pkg::bus_command_t proc2mem_command;
    logic [`XLEN-1:0]           proc2mem_addr;
    logic [`BLOCK_BITS-1:0]     proc2mem_data;
    logic                       fetch_valid;
    logic [`INST_BITS-1:0]      fetch_inst;
    logic [`XLEN-1:0]           fetch_pc;
    logic [`XLEN-1:0]           fetch_npc;

    int errors = 0;
    int cycle = 0;
    // pcs taken by decode in order
    logic [`XLEN-1:0] seen_pc [$];
    // data traffic per cycle
    bit               data_busy    [TIMEOUT_CYCLES + 1];
    logic [`XLEN-1:0] data_addr_at [TIMEOUT_CYCLES + 1];

    frontend_top u_dut (.*);

    mem_model u_mem (.*, .stamp(cycle));

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a test never finished", cycle);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] image_word(input logic [`XLEN-1:0] addr);
        return addr ^ 32'ha5a5_0000;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want)
            else begin
                errors++;
                $display("[ERROR] %s is %h, expected %h", name, got, want);
            end
    endtask

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // block until decode has taken count packets
    task automatic wait_for_packets(input int count);
        while (seen_pc.size() < count)
            next_cycle();
    endtask

    task automatic stream_in_order(input int from, input int to);
        for (int i = from + 1; i < to; i++)
            check_value("fetch_pc", seen_pc[i], seen_pc[i - 1] + 32'd4);
    endtask

    // bus ownership and every packet decode takes
    always @(negedge clock) begin
        if (!reset && data_command != frontend_pkg::bus_none) begin
            data_busy[cycle]    = 1'b1;
            data_addr_at[cycle] = data_addr;
            check_value("proc2mem_command", proc2mem_command, data_command);
            check_value("proc2mem_addr", proc2mem_addr, data_addr);
            check_value("proc2mem_data", proc2mem_data, data_wdata);
        end
        if (!reset && fetch_valid && !decode_stall) begin
            check_value("fetch_inst", fetch_inst, image_word(fetch_pc));
            check_value("fetch_npc", fetch_npc, fetch_pc + 32'd4);
            seen_pc.push_back(fetch_pc);
        end
    end

    ////////////////////
    // tests
    ////////////////////

    task automatic after_reset();
        // port idle while reset is still held
        check_value("proc2mem_command", proc2mem_command, frontend_pkg::bus_none);
        check_value("fetch_valid", fetch_valid, 0);
        reset = 1'b0;
        while (mem2proc_tag == '0) begin
            check_value("fetch_valid", fetch_valid, 0);
            next_cycle();
        end
        check_value("fetch_valid", fetch_valid, 0);
        check_value("log_addr", u_mem.log_addr[0], `RESET_PC);
        check_value("log_cmd", u_mem.log_cmd[0], frontend_pkg::bus_load);
    endtask

    task automatic sequential_fetch();
        int hits;
        wait_for_packets(N_SEQ);
        check_value("fetch_pc", seen_pc[0], `RESET_PC);
        stream_in_order(0, N_SEQ);
        // first pass fits the cache so each block loads once
        for (int b = 0; b < N_SEQ / 2; b++) begin
            hits = 0;
            for (int i = 0; i < u_mem.log_count; i++) begin
                if (u_mem.log_addr[i] == `RESET_PC + 8 * b)
                    hits++;
            end
            assert (hits == 1)
                else begin
                    errors++;
                    $display("block at %h was loaded %0d times instead of once",
                             `RESET_PC + 8 * b, hits);
                end
        end
    endtask

    task automatic data_priority();
        int start;
        int log_start;
        int cyc;
        int n_data;
        start     = seen_pc.size();
        log_start = u_mem.log_count;
        n_data    = 0;
        // back to back, long enough to cover an icache miss
        for (int k = 0; k < N_RUN; k++) begin
            data_command = k[0] ? frontend_pkg::bus_store : frontend_pkg::bus_load;
            data_addr    = DATA_BASE + 8 * k;
            data_wdata   = {$urandom, $urandom};
            next_cycle();
        end
        data_command = frontend_pkg::bus_none;
        wait_for_packets(start + N_RUN);
        stream_in_order(start - 1, start + N_RUN);
        // an entry in a data cycle must be the data request
        for (int i = log_start; i < u_mem.log_count; i++) begin
            cyc = u_mem.log_cycle[i];
            if (data_busy[cyc]) begin
                check_value("log_addr", u_mem.log_addr[i], data_addr_at[cyc]);
                n_data++;
            end
        end
        check_value("data requests logged", n_data, N_RUN);
    endtask

    task automatic refusal_retry();
        int               start;
        int               log_start;
        logic [`XLEN-1:0] held_addr;
        start     = seen_pc.size();
        log_start = u_mem.log_count;
        while (proc2mem_command != frontend_pkg::bus_load)
            next_cycle();
        held_addr = proc2mem_addr;
        refuse    = 1'b1;
        repeat ($urandom_range(8, 1)) begin
            check_value("proc2mem_command", proc2mem_command, frontend_pkg::bus_load);
            check_value("proc2mem_addr", proc2mem_addr, held_addr);
            next_cycle();
        end
        refuse = 1'b0;
        wait_for_packets(start + N_RUN);
        stream_in_order(start - 1, start + N_RUN);
        check_value("log_addr", u_mem.log_addr[log_start], held_addr);
    endtask

    task automatic stall_hold();
        int                    start;
        int                    idx;
        logic [`INST_BITS-1:0] held_inst;
        logic [`XLEN-1:0]      held_pc;
        logic [`XLEN-1:0]      held_npc;
        start = seen_pc.size();
        while (!fetch_valid)
            next_cycle();
        held_inst    = fetch_inst;
        held_pc      = fetch_pc;
        held_npc     = fetch_npc;
        decode_stall = 1'b1;
        repeat ($urandom_range(8, 2)) begin
            next_cycle();
            check_value("fetch_valid", fetch_valid, 1);
            check_value("fetch_inst", fetch_inst, held_inst);
            check_value("fetch_pc", fetch_pc, held_pc);
            check_value("fetch_npc", fetch_npc, held_npc);
        end
        decode_stall = 1'b0;
        idx          = seen_pc.size();
        wait_for_packets(start + N_RUN);
        check_value("fetch_pc", seen_pc[idx], held_pc);
        check_value("fetch_pc", seen_pc[idx + 1], held_pc + 32'd4);
        stream_in_order(start - 1, start + N_RUN);
    endtask

    task automatic redirect_to(input logic [`XLEN-1:0] target);
        int first;
        repeat ($urandom_range(3, 0))
            next_cycle();
        branch_req    = 1'b1;
        branch_target = target;
        next_cycle();
        branch_req = 1'b0;
        // squashed slot right after the pulse
        check_value("fetch_valid", fetch_valid, 0);
        first = seen_pc.size();
        wait_for_packets(first + N_RUN);
        check_value("fetch_pc", seen_pc[first], target);
        stream_in_order(first, first + N_RUN);
    endtask

    initial begin
        void'($urandom(42));
        clock         = 1'b0;
        reset         = 1'b1;
        data_command  = frontend_pkg::bus_none;
        data_addr     = '0;
        data_wdata    = '0;
        decode_stall  = 1'b0;
        branch_req    = 1'b0;
        branch_target = '0;
        refuse        = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        after_reset();
        sequential_fetch();
        data_priority();
        refusal_retry();
        stall_hold();
        // cold block entered at its upper word
        redirect_to(32'h0000_0404);
        // line still cached
        redirect_to(32'h0000_0048);
        $display("summary: %0d packets checked, %0d errors", seen_pc.size(), errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: list.f
+incdir+verilog
verilog/frontend_pkg.sv
verilog/mem_arbiter.sv
verilog/icache.sv
verilog/fetch_unit.sv
verilog/frontend_top.sv
bench/mem_model.sv
bench/frontend_tb.sv

// File: run.sh
#!/bin/sh
# build the frontend testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module frontend_tb \
    -o frontend_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/frontend_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log || exit 1
exit 0
